/* filelist.f */
+incdir+rtl
rtl/reduce_data_pkg.sv
rtl/reduce_flow_pkg.sv
rtl/reduce_vec_if.sv
rtl/adder_var_comb.sv
rtl/reduce_node.sv
rtl/reduce_tree.sv
rtl/reduce_in_fifo.sv
rtl/reduce_issue.sv
rtl/reduce_top.sv
test/reduce_assertions.sv
test/tb_reduce_top.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_reduce_top
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_reduce_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "reduce_consts.svh"

module tb_reduce_top;
    import reduce_data_pkg::*;

    localparam int NUM_VECTORS = 400;
    localparam int CLK_HALF    = 20;
    // one long downstream stall starts at this vector count
    localparam int HOLD_AT     = 150;
    localparam int HOLD_CYCLES = 200;

    logic       clk;
    logic       reset;
    logic       in_valid;
    lane_mask_t in_mask;
    lane_vec_t  in_data;
    logic       in_credit;
    logic       out_credit;
    logic       out_valid;
    sum_t       out_sum;

    // reference model state
    sum_t expected_q [$];
    // one entry per vector in the buffer, set when its mask is nonzero
    bit   sent_nonzero_q [$];
    int   pop_cycle_q [$];
    int   cycle;
    int   up_credits;
    int   sent;
    int   results;
    int   returned;
    int   pending_returns;
    int   hold_left;
    bit   hold_done;
    bit   starved_seen;

    reduce_top DUT
    (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_valid      (in_valid),
        .i_lane_mask  (in_mask),
        .i_lane_data  (in_data),
        .o_in_credit  (in_credit),
        .i_out_credit (out_credit),
        .o_valid      (out_valid),
        .o_sum        (out_sum)
    );

    bind reduce_top reduce_assertions u_assertions
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_in_valid     (i_valid),
        .i_in_credit    (o_in_credit),
        .i_out_credit   (i_out_credit),
        .i_result_valid (o_valid)
    );

    always #CLK_HALF clk = ~clk;

    // cycle stamp for latency
    always @(posedge clk)
        cycle <= cycle + 1;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
            stop_with_failure($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                                        name, got, expected));
    endtask

    // mix of full, single lane, empty and sparse masks
    function automatic lane_mask_t random_mask();
        case ($urandom % 8)
            0, 1:    return '1;
            2, 3:    return lane_mask_t'(1 << ($urandom % `REDUCE_LANES));
            4:       return '0;
            default: return lane_mask_t'($urandom);
        endcase
    endfunction

    // sum of the lanes whose mask bit is set
    function automatic sum_t masked_sum(input lane_mask_t mask, input lane_vec_t data);
        sum_t total;
        total = '0;
        for (int i = 0; i < `REDUCE_LANES; i++)
            if (mask[i])
                total = total + sum_t'(data[i]);
        return total;
    endfunction

    ////////////////////////////////////////
    // sampled on the falling edge
    ////////////////////////////////////////
    task automatic observe_outputs();
        sum_t expected;
        if (in_credit)
        begin
            if (sent_nonzero_q.size() == 0)
                stop_with_failure("o_in_credit returned with no vector in the buffer");
            up_credits++;
            // credit comes one cycle after the pop
            if (sent_nonzero_q.pop_front())
                pop_cycle_q.push_back(cycle - 1);
        end
        check_value("o_in_credit over depth", 32'(up_credits > `REDUCE_FIFO_DEPTH), 0);
        // late in the stall the buffer is full and stuck
        if (hold_left > 0 && hold_left < 50)
            check_value("o_in_credit under back-pressure", 32'(in_credit), 0);
        if (out_valid)
        begin
            if (expected_q.size() == 0 || pop_cycle_q.size() == 0)
                stop_with_failure("o_valid raised with no vector outstanding");
            expected = expected_q.pop_front();
            check_value("o_sum", 32'(out_sum), 32'(expected));
            check_value("o_valid latency", cycle - pop_cycle_q.pop_front(), 3);
            results++;
            pending_returns++;
            check_value("o_valid beyond credits",
                        32'(results > `REDUCE_OUT_CREDITS + returned), 0);
        end
    endtask

    task automatic drive_inputs();
        in_valid   = 1'b0;
        out_credit = 1'b0;
        // first vectors go back to back and the rest in about 60% of credited cycles
        if (sent < NUM_VECTORS && up_credits > 0 &&
            (sent < `REDUCE_FIFO_DEPTH || $urandom % 100 < 60))
        begin
            in_mask = random_mask();
            for (int i = 0; i < `REDUCE_LANES; i++)
                in_data[i] = lane_t'($urandom);
            in_valid = 1'b1;
            up_credits--;
            sent++;
            sent_nonzero_q.push_back(in_mask != '0);
            if (in_mask != '0)
                expected_q.push_back(masked_sum(in_mask, in_data));
        end
        if (!hold_done && sent == HOLD_AT)
        begin
            hold_left = HOLD_CYCLES;
            hold_done = 1'b1;
        end
        // downstream returns freed slots after random delays
        if (hold_left > 0)
        begin
            hold_left--;
            if (up_credits == 0)
                starved_seen = 1'b1;
        end
        else if (pending_returns > 0 && $urandom % 100 < 35)
        begin
            out_credit = 1'b1;
            pending_returns--;
            returned++;
        end
    endtask

    initial
    begin
        void'($urandom(79783));
        clk             = 1'b0;
        reset           = 1'b1;
        in_valid        = 1'b0;
        in_mask         = '0;
        in_data         = '0;
        out_credit      = 1'b0;
        cycle           = 0;
        up_credits      = `REDUCE_FIFO_DEPTH;
        sent            = 0;
        results         = 0;
        returned        = 0;
        pending_returns = 0;
        hold_left       = 0;
        hold_done       = 1'b0;
        starved_seen    = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("o_valid after reset", 32'(out_valid), 0);
        check_value("o_in_credit after reset", 32'(in_credit), 0);
        // run until all sent, all results in and all upstream credits back
        while (sent < NUM_VECTORS || expected_q.size() != 0 ||
               up_credits != `REDUCE_FIFO_DEPTH)
        begin
            observe_outputs();
            drive_inputs();
            @(negedge clk);
        end
        check_value("upstream starvation seen", 32'(starved_seen), 1);
        check_value("pending pop stamps", pop_cycle_q.size(), 0);
        $display("Everything OK");
        $finish;
    end

    // 40 cycles per vector plus margin
    initial
    begin
        repeat (NUM_VECTORS * 40 + 1000) @(posedge clk);
        stop_with_failure("timeout: the run did not finish in the allowed time");
    end

endmodule

`default_nettype wire

/* test/reduce_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

`include "reduce_consts.svh"

// credit and valid rules on the top level ports
module reduce_assertions
(
    input wire logic i_clk,
    input wire logic i_reset,
    input wire logic i_in_valid,
    input wire logic i_in_credit,
    input wire logic i_out_credit,
    input wire logic i_result_valid
);

    // result slots downstream still has free
    int out_held;
    // vectors taken in, not yet credited back
    int in_owed;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            out_held <= `REDUCE_OUT_CREDITS;
            in_owed  <= 0;
        end
        else
        begin
            out_held <= out_held + int'(i_out_credit) - int'(i_result_valid);
            in_owed  <= in_owed + int'(i_in_valid) - int'(i_in_credit);
        end
    end

    ////////////////////////////////////////
    // properties
    ////////////////////////////////////////

    // a result needs a free downstream slot
    a_result_credit : assert property (@(posedge i_clk) disable iff (i_reset)
        i_result_valid |-> (out_held > 0))
        else $error("o_valid raised with no result credit held");

    // upstream never ends up above its initial credit count
    a_in_credit : assert property (@(posedge i_clk) disable iff (i_reset)
        i_in_credit |-> (in_owed > 0))
        else $error("o_in_credit returned for a vector never received");

    // sync reset clears both outputs one edge later
    a_reset_quiet : assert property (@(posedge i_clk)
        i_reset |=> (!i_result_valid && !i_in_credit))
        else $error("outputs active while in reset");

endmodule

`default_nettype wire

/* rtl/reduce_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "reduce_consts.svh"

// credited lane reduction, buffer then issue then adder tree
module reduce_top
(
    input  wire logic                       i_clk,
    input  wire logic                       i_reset,
    // upstream, credited
    input  wire logic                       i_valid,
    input  wire reduce_data_pkg::lane_mask_t i_lane_mask,
    input  wire reduce_data_pkg::lane_vec_t  i_lane_data,
    output logic                            o_in_credit,
    // downstream, credited
    input  wire logic                       i_out_credit,
    output logic                            o_valid,
    output reduce_data_pkg::sum_t           o_sum
);
    import reduce_data_pkg::*;

    reduce_vec_if vec_bus ();

    // issue to tree
    lane_mask_t tree_valid;
    lane_vec_t  tree_data;

    reduce_in_fifo u_in_fifo
    (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_valid     (i_valid),
        .i_lane_mask (i_lane_mask),
        .i_lane_data (i_lane_data),
        .o_in_credit (o_in_credit),
        .vec         (vec_bus.fifo)
    );

    reduce_issue u_issue
    (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_out_credit (i_out_credit),
        .vec          (vec_bus.issue),
        .o_tree_valid (tree_valid),
        .o_tree_data  (tree_data)
    );

    reduce_tree #(.DATA_WIDTH(`REDUCE_LANE_W)) u_tree
    (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_valid (tree_valid),
        .i_data  (tree_data),
        .o_valid (o_valid),
        .o_sum   (o_sum)
    );

endmodule

`default_nettype wire

/* rtl/reduce_issue.sv */
`timescale 1ns/100ps
`default_nettype none

`include "reduce_consts.svh"

// result credit tracking, pops the buffer into the tree
module reduce_issue
(
    input  wire logic                     i_clk,
    input  wire logic                     i_reset,
    input  wire logic                     i_out_credit,
    reduce_vec_if.issue                   vec,
    output reduce_data_pkg::lane_mask_t   o_tree_valid,
    output reduce_data_pkg::lane_vec_t    o_tree_data
);
    import reduce_flow_pkg::*;

    credit_t credits;
    logic    mask_nonzero;
    logic    credit_held;
    logic    pop_fire;
    logic    reserve;

    assign mask_nonzero = |vec.mask;
    assign credit_held  = (credits != '0);

    // empty masks need no result slot
    assign pop_fire = ~vec.empty & (credit_held | ~mask_nonzero);
    assign reserve  = pop_fire & mask_nonzero;
    assign vec.pop  = pop_fire;

    ////////////////////////////////////////
    // result credits
    ////////////////////////////////////////
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            credits <= credit_t'(`REDUCE_OUT_CREDITS);
        else
            // reserve and return may land in the same cycle
            credits <= credits - credit_t'(reserve) + credit_t'(i_out_credit);
    end

    // mask only reaches the tree on a pop
    assign o_tree_valid = pop_fire ? vec.mask : '0;
    assign o_tree_data  = vec.data;

endmodule

`default_nettype wire

/* rtl/reduce_in_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

`include "reduce_consts.svh"

// input buffer, one upstream credit per slot
module reduce_in_fifo
(
    input  wire logic                       i_clk,
    input  wire logic                       i_reset,
    input  wire logic                       i_valid,
    input  wire reduce_data_pkg::lane_mask_t i_lane_mask,
    input  wire reduce_data_pkg::lane_vec_t  i_lane_data,
    output logic                            o_in_credit,
    reduce_vec_if.fifo                      vec
);
    import reduce_data_pkg::*;

    localparam int PTR_W = $clog2(`REDUCE_FIFO_DEPTH);

    // extra msb tells full from empty
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           pop_fire;

    lane_mask_t mask_mem [`REDUCE_FIFO_DEPTH];
    lane_vec_t  data_mem [`REDUCE_FIFO_DEPTH];

    assign pop_fire  = vec.pop & ~vec.empty;
    assign vec.empty = (wr_ptr == rd_ptr);

    // head entry
    assign vec.mask = mask_mem[rd_ptr[PTR_W-1:0]];
    assign vec.data = data_mem[rd_ptr[PTR_W-1:0]];

    ////////////////////////////////////////
    // pointers and credit return
    ////////////////////////////////////////
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            o_in_credit <= 1'b0;
        end
        else
        begin
            // upstream only sends against a credit, so a write always has room
            if (i_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_fire)
                rd_ptr <= rd_ptr + 1'b1;
            // freed slot goes back to upstream next cycle
            o_in_credit <= pop_fire;
        end
    end

    // storage
    always_ff @(posedge i_clk)
    begin
        if (i_valid)
        begin
            mask_mem[wr_ptr[PTR_W-1:0]] <= i_lane_mask;
            data_mem[wr_ptr[PTR_W-1:0]] <= i_lane_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/reduce_tree.sv */
`timescale 1ns/100ps
`default_nettype none

`include "reduce_consts.svh"

// three level tree, 8 lanes down to one sum, one cycle per level
module reduce_tree
#(
    parameter DATA_WIDTH = `REDUCE_LANE_W
)
(
    input  wire logic                       i_clk,
    input  wire logic                       i_reset,
    input  wire reduce_data_pkg::lane_mask_t i_valid,
    input  wire reduce_data_pkg::lane_vec_t  i_data,
    output logic                            o_valid,
    output reduce_data_pkg::sum_t           o_sum
);

    // level outputs, one bit wider per level
    logic [3:0]          l1_valid;
    logic [DATA_WIDTH:0] l1_data [4];
    logic [1:0]          l2_valid;
    logic [DATA_WIDTH+1:0] l2_data [2];

    ////////////////////////////////////////
    // level 1, adjacent lane pairs
    ////////////////////////////////////////
    for (genvar g = 0; g < 4; g++)
    begin : g_l1
        reduce_node #(.DATA_WIDTH(DATA_WIDTH)) u_node
        (
            .i_clk     (i_clk),
            .i_reset   (i_reset),
            .i_valid_a (i_valid[2*g+1]),
            .i_valid_b (i_valid[2*g]),
            .i_data_a  (i_data[2*g+1]),
            .i_data_b  (i_data[2*g]),
            .o_valid   (l1_valid[g]),
            .o_data    (l1_data[g])
        );
    end

    ////////////////////////////////////////
    // level 2, pairs of level 1 sums
    ////////////////////////////////////////
    for (genvar g = 0; g < 2; g++)
    begin : g_l2
        reduce_node #(.DATA_WIDTH(DATA_WIDTH+1)) u_node
        (
            .i_clk     (i_clk),
            .i_reset   (i_reset),
            .i_valid_a (l1_valid[2*g+1]),
            .i_valid_b (l1_valid[2*g]),
            .i_data_a  (l1_data[2*g+1]),
            .i_data_b  (l1_data[2*g]),
            .o_valid   (l2_valid[g]),
            .o_data    (l2_data[g])
        );
    end

    // root, its output is the vector sum
    reduce_node #(.DATA_WIDTH(DATA_WIDTH+2)) u_root
    (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_valid_a (l2_valid[1]),
        .i_valid_b (l2_valid[0]),
        .i_data_a  (l2_data[1]),
        .i_data_b  (l2_data[0]),
        .o_valid   (o_valid),
        .o_data    (o_sum)
    );

endmodule

`default_nettype wire

/* rtl/reduce_node.sv */
`timescale 1ns/100ps
`default_nettype none

// one registered node of the adder tree
module reduce_node
#(
    parameter DATA_WIDTH = 16
)
(
    input  wire logic                  i_clk,
    input  wire logic                  i_reset,
    input  wire logic                  i_valid_a,
    input  wire logic                  i_valid_b,
    input  wire logic [DATA_WIDTH-1:0] i_data_a,
    input  wire logic [DATA_WIDTH-1:0] i_data_b,
    output logic                       o_valid,
    output logic [DATA_WIDTH:0]        o_data
);
    import reduce_flow_pkg::*;

    node_op_e            node_op;
    logic                add_valid;
    logic [DATA_WIDTH:0] add_data;

    assign node_op = node_op_decode(i_valid_a, i_valid_b);

    // adder only runs when both sides carry a lane
    adder_var_comb #(.DATA_WIDTH(DATA_WIDTH)) u_adder
    (
        .i_valid    ({i_valid_a, i_valid_b}),
        .i_data_bus ({i_data_a, i_data_b}),
        .i_en       (node_op == NODE_ADD),
        .o_valid    (add_valid),
        .o_data_bus (add_data)
    );

    // any valid operand gives a valid result
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            o_valid <= 1'b0;
        else
            o_valid <= add_valid | (node_op == NODE_FWD_A) | (node_op == NODE_FWD_B);
    end

    always_ff @(posedge i_clk)
    begin
        case (node_op)
            NODE_ADD:   o_data <= add_data;
            // lone operand passes through, zero extended
            NODE_FWD_A: o_data <= {1'b0, i_data_a};
            NODE_FWD_B: o_data <= {1'b0, i_data_b};
            // idle keeps the last value
            default:    o_data <= o_data;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/adder_var_comb.sv */
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////
// two operand adder, combinational
// data_a in the upper half of the bus, data_b in the lower half
// sum is one bit wider than an operand
////////////////////////////////////////
module adder_var_comb
#(
    parameter DATA_WIDTH = 16
)
(
    // bit 1 qualifies data_a, bit 0 qualifies data_b
    input  wire logic [1:0]            i_valid,
    input  wire logic [2*DATA_WIDTH-1:0] i_data_bus,
    input  wire logic                  i_en,
    output logic                       o_valid,
    output logic [DATA_WIDTH:0]        o_data_bus
);

    logic calc_en;

    // both operands present and enabled
    assign calc_en = i_valid[0] & i_valid[1] & i_en;

    always_comb
    begin
        if (calc_en)
        begin
            o_data_bus = i_data_bus[DATA_WIDTH +: DATA_WIDTH] + i_data_bus[0 +: DATA_WIDTH];
            o_valid    = 1'b1;
        end
        else
        begin
            // data is don't care without valid
            o_data_bus = {(DATA_WIDTH+1){1'bx}};
            o_valid    = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* rtl/reduce_vec_if.sv */
`timescale 1ns/100ps
`default_nettype none

// head of the input buffer, as seen by the issue stage
interface reduce_vec_if;
    import reduce_data_pkg::*;

    logic       empty;
    lane_mask_t mask;
    lane_vec_t  data;
    // consumes the head entry when empty is low
    logic       pop;

    modport fifo  (output empty, output mask, output data, input pop);
    modport issue (input empty, input mask, input data, output pop);

endinterface

`default_nettype wire

/* rtl/reduce_flow_pkg.sv */
`default_nettype none

package reduce_flow_pkg;

    // what a tree node does with its operand pair
    typedef enum logic [1:0]
    {
        NODE_ADD   = 2'b00,
        NODE_FWD_A = 2'b01,
        NODE_FWD_B = 2'b10,
        NODE_IDLE  = 2'b11
    } node_op_e;

    // result credit counter
    typedef logic [2:0] credit_t;

    // opcode from the two operand valids
    function automatic node_op_e node_op_decode(input logic valid_a, input logic valid_b);
        case ({valid_a, valid_b})
            2'b11:   return NODE_ADD;
            2'b10:   return NODE_FWD_A;
            2'b01:   return NODE_FWD_B;
            default: return NODE_IDLE;
        endcase
    endfunction

endpackage

`default_nettype wire

/* rtl/reduce_data_pkg.sv */
`default_nettype none

`include "reduce_consts.svh"

package reduce_data_pkg;

    // one lane of a vector
    typedef logic [`REDUCE_LANE_W-1:0] lane_t;

    // all lanes, lane 0 in the low bits
    typedef lane_t [`REDUCE_LANES-1:0] lane_vec_t;

    // one valid bit per lane
    typedef logic [`REDUCE_LANES-1:0] lane_mask_t;

    // reduced sum, wide enough for all lanes at full scale
    typedef logic [`REDUCE_SUM_W-1:0] sum_t;

endpackage

`default_nettype wire

/* rtl/reduce_consts.svh */
`ifndef REDUCE_CONSTS_SVH
`define REDUCE_CONSTS_SVH

// lanes per input vector
`define REDUCE_LANES 8

// width of one lane
`define REDUCE_LANE_W 16

// levels in the binary adder tree
`define REDUCE_TREE_DEPTH 3

// each tree level grows the sum by one bit
`define REDUCE_SUM_W (`REDUCE_LANE_W + `REDUCE_TREE_DEPTH)

// input buffer slots, also the upstream credits after reset
`define REDUCE_FIFO_DEPTH 4

// result credits held after reset
`define REDUCE_OUT_CREDITS 2

`endif
